// ==== logic/cpuTypesPkg.sv ====
package cpuTypesPkg;

    localparam int DataWidth = 32;
    localparam int AddrWidth = 32;
    localparam int TagWidth  = 5;

    // operand and immediate values.
    typedef logic [DataWidth-1:0] dataT;

    // instruction address.
    typedef logic [AddrWidth-1:0] addrT;

    // producer slot in the reorder buffer.
    typedef logic [TagWidth-1:0] tagT;

    // zero tag means the value is already there.
    localparam tagT tagFree = '0;

    // funct3 of the branch group, jalr in the unused slot.
    typedef enum logic [2:0] {
        brEq   = 3'b000,
        brNe   = 3'b001,
        brJalr = 3'b010,
        brLt   = 3'b100,
        brGe   = 3'b101,
        brLtu  = 3'b110,
        brGeu  = 3'b111
    } brOpT;

endpackage

// ==== logic/branchRsPkg.sv ====
package branchRsPkg;

    import cpuTypesPkg::*;

    // one write on a result bus.
    typedef struct packed {
        logic en;
        tagT  tag;
        dataT data;
    } cdbWriteT;

    // branch from the dispatcher.
    typedef struct packed {
        logic en;
        dataT opAVal;
        tagT  opATag;   // tagFree when opAVal is valid.
        dataT opBVal;
        tagT  opBTag;
        brOpT op;
        dataT imm;
        addrT pc;
        tagT  robTag;
        logic predTaken;
    } brAllocT;

    // branch leaving the station with both operands.
    typedef struct packed {
        dataT opA;
        dataT opB;
        brOpT op;
        dataT imm;
        addrT pc;
        tagT  robTag;
        logic predTaken;
    } brIssueT;

    typedef struct packed {
        logic valid;
        tagT  robTag;
        logic taken;
        addrT target;
        logic mispredict;
    } brResultT;

    typedef enum logic {
        stRun,
        stFlush
    } ctrlStateT;

endpackage

// ==== logic/operandCapture.sv ====
`timescale 1ns/10ps

module operandCapture
    import cpuTypesPkg::*;
    import branchRsPkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     rdy,
    input  logic     load,
    input  tagT      loadTag,
    input  dataT     loadData,
    input  logic     clear,
    input  cdbWriteT aluWrite,
    input  cdbWriteT lsWrite,
    output logic     present,
    output dataT     value
);

    tagT  tagQ;
    dataT valueQ;
    tagT  baseTag;
    dataT baseValue;
    tagT  nextTag;
    dataT nextValue;

    // a loaded pair is snooped too, so a broadcast in the alloc cycle is not lost.
    always_comb begin
        baseTag   = load ? loadTag : tagQ;
        baseValue = load ? loadData : valueQ;
        nextTag   = baseTag;
        nextValue = baseValue;
        if (baseTag != tagFree) begin
            if (aluWrite.en && aluWrite.tag == baseTag) begin
                nextTag   = tagFree;
                nextValue = aluWrite.data;
            end else if (lsWrite.en && lsWrite.tag == baseTag) begin
                nextTag   = tagFree;
                nextValue = lsWrite.data;
            end
        end
    end

    assign present = (nextTag == tagFree);  // same-cycle bypass.
    assign value   = nextValue;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tagQ <= tagFree;
        end else if (rdy) begin
            tagQ <= clear ? tagFree : nextTag;
        end
    end

    always_ff @(posedge clk) begin
        if (rdy) begin
            valueQ <= nextValue;
        end
    end

endmodule

// ==== logic/branchRsEntry.sv ====
`timescale 1ns/10ps

module branchRsEntry
    import cpuTypesPkg::*;
    import branchRsPkg::*;
#(
    parameter int AgeWidth = 3
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                rdy,
    input  cdbWriteT            aluWrite,
    input  cdbWriteT            lsWrite,
    input  brAllocT             alloc,
    input  logic                allocHit,
    input  logic [AgeWidth-1:0] stamp,
    input  logic                issueHit,
    input  logic                clear,
    output logic                valid,
    output logic                ready,
    output logic [AgeWidth-1:0] age,
    output brIssueT             issue
);

    logic presentA;
    logic presentB;
    dataT valueA;
    dataT valueB;
    brOpT opQ;
    dataT immQ;
    addrT pcQ;
    tagT  robTagQ;
    logic predTakenQ;

    operandCapture i_opA (
        .clk      (clk),
        .rst      (rst),
        .rdy      (rdy),
        .load     (allocHit),
        .loadTag  (alloc.opATag),
        .loadData (alloc.opAVal),
        .clear    (clear),
        .aluWrite (aluWrite),
        .lsWrite  (lsWrite),
        .present  (presentA),
        .value    (valueA)
    );

    operandCapture i_opB (
        .clk      (clk),
        .rst      (rst),
        .rdy      (rdy),
        .load     (allocHit),
        .loadTag  (alloc.opBTag),
        .loadData (alloc.opBVal),
        .clear    (clear),
        .aluWrite (aluWrite),
        .lsWrite  (lsWrite),
        .present  (presentB),
        .value    (valueB)
    );

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid <= 1'b0;
        end else if (rdy) begin
            if (clear) begin
                valid <= 1'b0;
            end else if (allocHit) begin
                valid <= 1'b1;
            end else if (issueHit) begin
                valid <= 1'b0;  // freed as it enters the branch unit.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rdy && allocHit) begin
            age        <= stamp;
            opQ        <= alloc.op;
            immQ       <= alloc.imm;
            pcQ        <= alloc.pc;
            robTagQ    <= alloc.robTag;
            predTakenQ <= alloc.predTaken;
        end
    end

    assign ready = valid && presentA && presentB;

    assign issue = '{opA: valueA, opB: valueB, op: opQ, imm: immQ, pc: pcQ,
                     robTag: robTagQ, predTaken: predTakenQ};

    // controller only targets free entries, and only for a real alloc.
    assert property (@(posedge clk) disable iff (rst) rdy && allocHit |-> alloc.en && !valid)
        else $error("alloc into an occupied branch station entry");

endmodule

// ==== logic/ageCounter.sv ====
`timescale 1ns/10ps

module ageCounter #(
    parameter int NumEntries = 4,
    parameter int AgeWidth   = $clog2(NumEntries) + 1
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                rdy,
    input  logic                allocTake,
    input  logic                issueTake,
    input  logic                clear,
    output logic [AgeWidth-1:0] stamp,
    output logic [AgeWidth-1:0] count
);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            stamp <= '0;
        end else if (rdy && allocTake) begin
            stamp <= stamp + 1'b1;  // wraps.
        end
    end

    // occupancy, alloc and issue may both land in one cycle.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count <= '0;
        end else if (rdy) begin
            if (clear) begin
                count <= '0;
            end else if (allocTake && !issueTake) begin
                count <= count + 1'b1;
            end else if (issueTake && !allocTake) begin
                count <= count - 1'b1;
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst) count <= AgeWidth'(NumEntries))
        else $error("branch station occupancy above NumEntries");

endmodule

// ==== logic/branchRsCtrl.sv ====
`timescale 1ns/10ps

module branchRsCtrl
    import branchRsPkg::*;
#(
    parameter int NumEntries = 4,
    parameter int AgeWidth   = $clog2(NumEntries) + 1
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  rdy,
    input  logic                  allocEn,
    input  logic [NumEntries-1:0] valid,
    input  logic [NumEntries-1:0] ready,
    input  logic [AgeWidth-1:0]   ages [NumEntries],
    input  brIssueT               issues [NumEntries],
    input  logic [AgeWidth-1:0]   count,
    input  logic                  mispredictSeen,
    output logic [NumEntries-1:0] allocSel,
    output logic [NumEntries-1:0] issueSel,
    output logic                  clearAll,
    output logic                  allocTake,
    output logic                  issueTake,
    output logic                  issueStrobe,
    output logic                  full,
    output logic                  flush,
    output brIssueT               issued
);

    ctrlStateT           state;
    ctrlStateT           stateNext;
    logic                freeFound;
    logic                haveOldest;
    int                  oldestIdx;
    logic [AgeWidth-1:0] ageDiff;

    always_comb begin
        stateNext = state;
        case (state)
            stRun:   if (mispredictSeen) stateNext = stFlush;
            stFlush: stateNext = stRun;  // one cycle only.
            default: stateNext = stRun;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= stRun;
        end else if (rdy) begin
            state <= stateNext;
        end
    end

    assign flush    = (state == stFlush);
    assign clearAll = flush;
    assign full     = flush || (count == AgeWidth'(NumEntries));  // dispatcher holds in flush.

    // lowest free slot.
    always_comb begin
        allocSel  = '0;
        freeFound = 1'b0;
        for (int i = 0; i < NumEntries; i++) begin
            if (!freeFound && !valid[i]) begin
                allocSel[i] = 1'b1;
                freeFound   = 1'b1;
            end
        end
        if (!allocEn || full) allocSel = '0;
    end

    // oldest ready entry; older means a small positive wrapping difference.
    always_comb begin
        oldestIdx  = 0;
        haveOldest = 1'b0;
        ageDiff    = '0;
        for (int i = 0; i < NumEntries; i++) begin
            ageDiff = ages[oldestIdx] - ages[i];
            if (ready[i] && (!haveOldest || (ageDiff != '0 && !ageDiff[AgeWidth-1]))) begin
                oldestIdx  = i;
                haveOldest = 1'b1;
            end
        end
        issueSel = '0;
        // nothing issues behind a mispredict or during the flush.
        if (haveOldest && state == stRun && !mispredictSeen) issueSel[oldestIdx] = 1'b1;
    end

    assign allocTake   = |allocSel;
    assign issueStrobe = |issueSel;
    assign issueTake   = issueStrobe;
    assign issued      = issues[oldestIdx];

    assert property (@(posedge clk) disable iff (rst) rdy && allocEn |-> !full)
        else $error("branch alloc while station full");

endmodule

// ==== logic/branchUnit.sv ====
`timescale 1ns/10ps

module branchUnit
    import cpuTypesPkg::*;
    import branchRsPkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     rdy,
    input  logic     issueStrobe,
    input  brIssueT  issued,
    output brResultT result
);

    logic taken;
    addrT jumpTarget;
    addrT target;
    logic validQ;
    logic mispredictQ;
    logic takenQ;
    addrT targetQ;
    tagT  robTagQ;

    always_comb begin
        case (issued.op)
            brEq:    taken = (issued.opA == issued.opB);
            brNe:    taken = (issued.opA != issued.opB);
            brLt:    taken = ($signed(issued.opA) < $signed(issued.opB));
            brGe:    taken = ($signed(issued.opA) >= $signed(issued.opB));
            brLtu:   taken = (issued.opA < issued.opB);
            brGeu:   taken = (issued.opA >= issued.opB);
            brJalr:  taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    // jalr drops bit 0 of the sum.
    assign jumpTarget = (issued.op == brJalr) ? ((issued.opA + issued.imm) & ~addrT'(1))
                                              : (issued.pc + issued.imm);
    assign target = taken ? jumpTarget : (issued.pc + addrT'(4));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            validQ      <= 1'b0;
            mispredictQ <= 1'b0;
        end else if (rdy) begin
            validQ      <= issueStrobe;
            mispredictQ <= issueStrobe && (taken != issued.predTaken);
        end
    end

    always_ff @(posedge clk) begin
        if (rdy && issueStrobe) begin
            takenQ  <= taken;
            targetQ <= target;
            robTagQ <= issued.robTag;
        end
    end

    assign result = '{valid: validQ, robTag: robTagQ, taken: takenQ,
                      target: targetQ, mispredict: mispredictQ};

endmodule

// ==== logic/branchStation.sv ====
`timescale 1ns/10ps

module branchStation
    import branchRsPkg::*;
#(
    parameter int NumEntries = 4,
    parameter int AgeWidth   = $clog2(NumEntries) + 1
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     rdy,
    input  brAllocT  alloc,
    input  cdbWriteT aluWrite,
    input  cdbWriteT lsWrite,
    output logic     full,
    output brResultT result,
    output logic     flush
);

    logic [NumEntries-1:0] entryValid;
    logic [NumEntries-1:0] entryReady;
    logic [NumEntries-1:0] allocSel;
    logic [NumEntries-1:0] issueSel;
    logic [AgeWidth-1:0]   entryAge [NumEntries];
    brIssueT               entryIssue [NumEntries];
    logic [AgeWidth-1:0]   stamp;
    logic [AgeWidth-1:0]   count;
    logic                  clearAll;
    logic                  allocTake;
    logic                  issueTake;
    logic                  issueStrobe;
    brIssueT               issued;

    for (genvar i = 0; i < NumEntries; i++) begin : gEntry
        branchRsEntry #(.AgeWidth(AgeWidth)) i_entry (
            .clk(clk), .rst(rst), .rdy(rdy),
            .aluWrite (aluWrite),
            .lsWrite  (lsWrite),
            .alloc    (alloc),
            .allocHit (allocSel[i]),
            .stamp    (stamp),
            .issueHit (issueSel[i]),
            .clear    (clearAll),
            .valid    (entryValid[i]),
            .ready    (entryReady[i]),
            .age      (entryAge[i]),
            .issue    (entryIssue[i])
        );
    end

    ageCounter #(.NumEntries(NumEntries), .AgeWidth(AgeWidth)) i_ageCounter (
        .clk(clk), .rst(rst), .rdy(rdy),
        .allocTake (allocTake),
        .issueTake (issueTake),
        .clear     (clearAll),
        .stamp     (stamp),
        .count     (count)
    );

    branchRsCtrl #(.NumEntries(NumEntries), .AgeWidth(AgeWidth)) i_branchRsCtrl (
        .clk(clk), .rst(rst), .rdy(rdy),
        .allocEn        (alloc.en),
        .valid          (entryValid),
        .ready          (entryReady),
        .ages           (entryAge),
        .issues         (entryIssue),
        .count          (count),
        .mispredictSeen (result.mispredict),  // only set with result.valid.
        .allocSel       (allocSel),
        .issueSel       (issueSel),
        .clearAll       (clearAll),
        .allocTake      (allocTake),
        .issueTake      (issueTake),
        .issueStrobe    (issueStrobe),
        .full           (full),
        .flush          (flush),
        .issued         (issued)
    );

    branchUnit i_branchUnit (
        .clk(clk), .rst(rst), .rdy(rdy),
        .issueStrobe (issueStrobe),
        .issued      (issued),
        .result      (result)
    );

endmodule

// ==== verification/tbClock.sv ====
`timescale 1ns/10ps

module tbClock #(
    parameter int HalfPeriod  = 2,
    parameter int ResetCycles = 10
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #HalfPeriod clk = ~clk;
    end

    // held over the first cycles, released on an edge.
    initial begin
        rst <= 1'b1;
        repeat (ResetCycles) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// ==== verification/branchStationTb.sv ====
`timescale 1ns/10ps

module branchStationTb
    import cpuTypesPkg::*;
    import branchRsPkg::*;
();

    localparam int NumEntries  = 4;
    localparam int ClkPeriod   = 4;
    localparam int ResetCycles = 10;
    localparam int NumCycles   = 4000;
    localparam int TimeoutNs   = (ResetCycles + NumCycles) * ClkPeriod + 400;

    logic     clk;
    logic     rst;
    logic     rdy      = 1'b0;
    brAllocT  alloc    = '0;
    cdbWriteT aluWrite = '0;
    cdbWriteT lsWrite  = '0;
    logic     full;
    brResultT result;
    logic     flush;

    logic [31:0] lfsr        = 32'h2d9e;
    logic [31:0] outstanding = '0;  // fake producers in flight, by tag.

    logic     mValid [NumEntries];
    tagT      mTagA  [NumEntries];
    tagT      mTagB  [NumEntries];
    dataT     mValA  [NumEntries];
    dataT     mValB  [NumEntries];
    brOpT     mOp    [NumEntries];
    dataT     mImm   [NumEntries];
    addrT     mPc    [NumEntries];
    tagT      mRob   [NumEntries];
    logic     mPred  [NumEntries];
    int       mSeq   [NumEntries];  // unwrapped stamp.
    int       nextSeq;
    logic     mFlush;
    brResultT mResult;
    int       issueCount = 0;
    int       flushCount = 0;
    int       fullCount  = 0;

    tbClock #(.HalfPeriod(ClkPeriod / 2), .ResetCycles(ResetCycles)) i_tbClock (
        .clk (clk),
        .rst (rst)
    );

    branchStation #(.NumEntries(NumEntries)) i_branchStation (
        .clk      (clk),
        .rst      (rst),
        .rdy      (rdy),
        .alloc    (alloc),
        .aluWrite (aluWrite),
        .lsWrite  (lsWrite),
        .full     (full),
        .result   (result),
        .flush    (flush)
    );

    // fibonacci lfsr, taps 32 22 2 1, one step per bit.
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic modelFull();
        int live;
        live = 0;
        for (int i = 0; i < NumEntries; i++) begin
            if (mValid[i]) live++;
        end
        return mFlush || live == NumEntries;
    endfunction

    // keeps live stamps within half the stamp range.
    function automatic logic windowOk();
        logic ok;
        ok = 1'b1;
        for (int i = 0; i < NumEntries; i++) begin
            if (mValid[i] && nextSeq - mSeq[i] > 3) ok = 1'b0;
        end
        return ok;
    endfunction

    function automatic brResultT resolve(input brOpT op, input dataT a, input dataT b,
                                         input dataT imm, input addrT pc, input tagT rob,
                                         input logic pred);
        brResultT r;
        logic     taken;
        addrT     sum;
        case (op)
            brEq:    taken = (a == b);
            brNe:    taken = (a != b);
            brLt:    taken = ($signed(a) < $signed(b));
            brGe:    taken = !($signed(a) < $signed(b));
            brLtu:   taken = (a < b);
            brGeu:   taken = !(a < b);
            default: taken = 1'b1;  // jalr.
        endcase
        sum = (op == brJalr) ? a + imm : pc + imm;
        r.valid      = 1'b1;
        r.robTag     = rob;
        r.taken      = taken;
        r.target     = !taken ? pc + 32'd4 : (op == brJalr) ? {sum[31:1], 1'b0} : sum;
        r.mispredict = taken != pred;
        return r;
    endfunction

    task automatic snoop(inout tagT tag, inout dataT val);
        if (tag != tagFree) begin
            if (aluWrite.en && aluWrite.tag == tag) begin
                tag = tagFree;
                val = aluWrite.data;
            end else if (lsWrite.en && lsWrite.tag == tag) begin
                tag = tagFree;
                val = lsWrite.data;
            end
        end
    endtask

    task automatic resetModel();
        for (int i = 0; i < NumEntries; i++) begin
            mValid[i] = 1'b0;
            mTagA[i]  = tagFree;
            mTagB[i]  = tagFree;
            mSeq[i]   = 0;
        end
        nextSeq     = 0;
        mFlush      = 1'b0;
        mResult     = '0;
        outstanding = '0;
    endtask

    // one clock edge of the station, with the inputs of the ending cycle.
    task automatic stepModel();
        tagT      nTagA [NumEntries];
        tagT      nTagB [NumEntries];
        dataT     nValA [NumEntries];
        dataT     nValB [NumEntries];
        int       allocIdx;
        int       issueIdx;
        logic     wasFull;
        brResultT nextResult;
        allocIdx   = -1;
        issueIdx   = -1;
        wasFull    = modelFull();
        nextResult = '0;
        for (int i = 0; i < NumEntries; i++) begin
            if (alloc.en && !wasFull && !mValid[i] && allocIdx < 0) allocIdx = i;
        end
        for (int i = 0; i < NumEntries; i++) begin
            nTagA[i] = (i == allocIdx) ? alloc.opATag : mTagA[i];
            nValA[i] = (i == allocIdx) ? alloc.opAVal : mValA[i];
            nTagB[i] = (i == allocIdx) ? alloc.opBTag : mTagB[i];
            nValB[i] = (i == allocIdx) ? alloc.opBVal : mValB[i];
            snoop(nTagA[i], nValA[i]);
            snoop(nTagB[i], nValB[i]);
            // oldest ready entry, held back behind a mispredict.
            if (mValid[i] && nTagA[i] == tagFree && nTagB[i] == tagFree && !mFlush &&
                !mResult.mispredict && (issueIdx < 0 || mSeq[i] < mSeq[issueIdx])) begin
                issueIdx = i;
            end
        end
        if (issueIdx >= 0) begin
            nextResult = resolve(mOp[issueIdx], nValA[issueIdx], nValB[issueIdx],
                                 mImm[issueIdx], mPc[issueIdx], mRob[issueIdx],
                                 mPred[issueIdx]);
            issueCount++;
        end
        for (int i = 0; i < NumEntries; i++) begin
            mTagA[i] = mFlush ? tagFree : nTagA[i];
            mTagB[i] = mFlush ? tagFree : nTagB[i];
            mValA[i] = nValA[i];
            mValB[i] = nValB[i];
            if (mFlush) begin
                mValid[i] = 1'b0;
            end else if (i == allocIdx) begin
                mValid[i] = 1'b1;
                mOp[i]    = alloc.op;
                mImm[i]   = alloc.imm;
                mPc[i]    = alloc.pc;
                mRob[i]   = alloc.robTag;
                mPred[i]  = alloc.predTaken;
                mSeq[i]   = nextSeq;
            end else if (i == issueIdx) begin
                mValid[i] = 1'b0;
            end
        end
        if (allocIdx >= 0) nextSeq++;
        mFlush = !mFlush && mResult.mispredict;
        if (mFlush) flushCount++;
        mResult = nextResult;
    endtask

    task automatic pickOperand(output tagT tag, output dataT val);
        if (randBits(1) != 0) begin
            tag = tagFree;
            val = (randBits(1) != 0) ? randBits(32) : randBits(3);  // small values meet often.
        end else begin
            tag = tagT'(randBits(3) + 1);
            val = randBits(32);  // stale until the bus delivers.
            outstanding[tag] = 1'b1;
        end
    endtask

    task automatic driveInputs();
        brAllocT  a;
        cdbWriteT alu;
        cdbWriteT ls;
        logic     goRdy;
        tagT      t;
        logic [2:0] opBits;
        a     = '0;
        alu   = '0;
        ls    = '0;
        goRdy = randBits(4) != 0;
        if (goRdy) begin
            t = tagT'(randBits(3) + 1);
            if (outstanding[t] && randBits(1) != 0) begin
                alu = '{en: 1'b1, tag: t, data: randBits(32)};
                outstanding[t] = 1'b0;
            end
            t = tagT'(randBits(3) + 1);
            if (outstanding[t] && randBits(1) != 0) begin
                ls = '{en: 1'b1, tag: t, data: randBits(32)};
                outstanding[t] = 1'b0;
            end
            if (!modelFull() && windowOk() && randBits(2) != 0) begin
                a.en = 1'b1;
                pickOperand(a.opATag, a.opAVal);
                pickOperand(a.opBTag, a.opBVal);
                opBits      = 3'(randBits(3));
                a.op        = (opBits == 3'b011) ? brEq : brOpT'(opBits);
                a.imm       = randBits(12);
                if (randBits(1) != 0) a.imm = a.imm | 32'hffff_f000;  // backward offset.
                a.pc        = addrT'(randBits(30)) << 2;
                a.robTag    = tagT'(randBits(5));
                a.predTaken = randBits(1) != 0;
            end
        end
        rdy      <= goRdy;
        alloc    <= a;
        aluWrite <= alu;
        lsWrite  <= ls;
    endtask

    task automatic checkResult(input brResultT got, input brResultT exp);
        if (got.valid !== exp.valid || got.mispredict !== exp.mispredict ||
            (exp.valid && (got.robTag !== exp.robTag || got.taken !== exp.taken ||
                           got.target !== exp.target))) begin
            $display("Fail %0t result valid=%0b tag=%0d taken=%0b target=%h mis=%0b",
                     $time, got.valid, got.robTag, got.taken, got.target, got.mispredict);
            $display("  expected valid=%0b tag=%0d taken=%0b target=%h mis=%0b",
                     exp.valid, exp.robTag, exp.taken, exp.target, exp.mispredict);
            $display("SIMULATION FAILED");
            $fatal(1, "branch result mismatch");
        end
    endtask

    task automatic checkFlag(input logic got, input logic exp);
        if (got !== exp) begin
            $display("Fail %0t full is %0b, expected %0b", $time, got, exp);
            $display("SIMULATION FAILED");
            $fatal(1, "full mismatch");
        end
    endtask

    task automatic checkFlush(input logic got, input logic exp);
        if (got !== exp) begin
            $display("Fail %0t flush is %0b, expected %0b", $time, got, exp);
            $display("SIMULATION FAILED");
            $fatal(1, "flush mismatch");
        end
    endtask

    always @(posedge clk) begin : driveAndModel
        if (rst) begin
            resetModel();
            rdy      <= 1'b0;
            alloc    <= '0;
            aluWrite <= '0;
            lsWrite  <= '0;
        end else begin
            if (rdy) stepModel();
            driveInputs();
        end
    end

    // outputs settle well before the falling edge.
    always @(negedge clk) begin : checkOutputs
        if (!rst) begin
            checkResult(result, mResult);
            checkFlag(full, modelFull());
            checkFlush(flush, mFlush);
            if (modelFull() && !mFlush) fullCount++;
        end
    end

    initial begin : watchdog
        #TimeoutNs;
        $display("watchdog expired before the test finished");
        $display("SIMULATION FAILED");
        $fatal(1, "timeout");
    end

    initial begin : runTest
        @(negedge rst);
        repeat (NumCycles) @(posedge clk);
        if (issueCount == 0 || flushCount == 0 || fullCount == 0) begin
            $display("stimulus never reached results, flushes or a full station");
            $display("SIMULATION FAILED");
            $fatal(1, "coverage hole");
        end else begin
            $display("%0d results, %0d flushes checked", issueCount, flushCount);
            $display("SIMULATION PASSED");
            $finish;
        end
    end

endmodule

// ==== vlog.f ====
logic/cpuTypesPkg.sv
logic/branchRsPkg.sv
logic/operandCapture.sv
logic/branchRsEntry.sv
logic/ageCounter.sv
logic/branchRsCtrl.sv
logic/branchUnit.sv
logic/branchStation.sv
verification/tbClock.sv
verification/branchStationTb.sv

// ==== run.sh ====
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module branchStationTb \
    -f vlog.f -o simBranchStation
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

./obj_dir/simBranchStation
status=$?
if [ $status -ne 0 ]; then
    echo "simulation ended with status $status"
    exit $status
fi

exit 0
